// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_scariv_l2c
FILELIST = scariv_l2c.f
LOG      = sim.log
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)
	./$(OBJDIR)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: scariv_l2c.f
scariv_l2c_pkg.sv
scariv_l2c_arbiter.sv
scariv_l2c_splitter.sv
scariv_l2c_ram.sv
scariv_l2c_serial.sv
scariv_l2c_fabric.sv
tb_scariv_l2c.sv

// File: scariv_l2c_arbiter.sv
`default_nettype none

module scariv_l2c_arbiter
  import scariv_l2c_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_scariv_reset_n,

  // loader port
  input  logic      i_ldr_req_valid,
  input  l2_req_t   i_ldr_req,
  output logic      o_ldr_req_ready,
  output logic      o_ldr_resp_valid,
  output l2_resp_t  o_ldr_resp,
  input  logic      i_ldr_resp_ready,

  // core port
  input  logic      i_core_req_valid,
  input  l2_req_t   i_core_req,
  output logic      o_core_req_ready,
  output logic      o_core_resp_valid,
  output l2_resp_t  o_core_resp,
  input  logic      i_core_resp_ready,

  // downstream
  output logic      o_fab_req_valid,
  output fab_req_t  o_fab_req,
  input  logic      i_fab_req_ready,
  input  logic      i_fab_resp_valid,
  input  fab_resp_t i_fab_resp,
  output logic      o_fab_resp_ready
);

  logic     r_core_hold;  // core presented, not yet taken
  logic     w_ldr_gnt;
  logic     w_core_gnt;
  l2_req_t  w_sel_req;
  l2_resp_t w_resp;
  logic     w_resp_core;

  // loader wins unless a core handshake is already open
  assign w_ldr_gnt        = i_ldr_req_valid & ~r_core_hold;
  assign w_core_gnt       = i_core_req_valid & (r_core_hold | ~i_ldr_req_valid);
  assign o_ldr_req_ready  = ~r_core_hold & i_fab_req_ready;
  assign o_core_req_ready = (r_core_hold | ~i_ldr_req_valid) & i_fab_req_ready;

  assign w_sel_req       = w_core_gnt ? i_core_req : i_ldr_req;
  assign o_fab_req_valid = w_ldr_gnt | w_core_gnt;
  assign o_fab_req       = '{cmd:     w_sel_req.cmd,
                             addr:    w_sel_req.addr,
                             tag:     fab_tag_t'{src: w_core_gnt ? SRC_CORE : SRC_LDR,
                                                 tag: w_sel_req.tag},
                             data:    w_sel_req.data,
                             byte_en: w_sel_req.byte_en};

  always_ff @(posedge i_clk) begin
    if (i_scariv_reset_n) begin
      r_core_hold <= 1'b0;
    end else begin
      r_core_hold <= w_core_gnt & ~i_fab_req_ready;
    end
  end

  // ------------------------------
  // response steering by source bit
  // ------------------------------
  assign w_resp_core       = i_fab_resp.tag.src == SRC_CORE;
  assign w_resp            = '{tag: i_fab_resp.tag.tag, data: i_fab_resp.data};
  assign o_ldr_resp        = w_resp;
  assign o_core_resp       = w_resp;
  assign o_ldr_resp_valid  = i_fab_resp_valid & ~w_resp_core;
  assign o_core_resp_valid = i_fab_resp_valid & w_resp_core;
  assign o_fab_resp_ready  = w_resp_core ? i_core_resp_ready : i_ldr_resp_ready;

  // one requester per transfer
  a_gnt_onehot: assert property (@(posedge i_clk) disable iff (i_scariv_reset_n)
    $onehot0({i_ldr_req_valid & o_ldr_req_ready, i_core_req_valid & o_core_req_ready}));

endmodule

`default_nettype wire

// File: scariv_l2c_fabric.sv
`default_nettype none

module scariv_l2c_fabric
  import scariv_l2c_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_scariv_reset_n,

  input  logic       i_ldr_req_valid,
  input  l2_req_t    i_ldr_req,
  output logic       o_ldr_req_ready,
  output logic       o_ldr_resp_valid,
  output l2_resp_t   o_ldr_resp,
  input  logic       i_ldr_resp_ready,

  input  logic       i_core_req_valid,
  input  l2_req_t    i_core_req,
  output logic       o_core_req_ready,
  output logic       o_core_resp_valid,
  output l2_resp_t   o_core_resp,
  input  logic       i_core_resp_ready,

  output logic       o_serial_valid,
  output logic [7:0] o_serial_char,
  output logic       o_decode_err
);

  // ------------------------------
  // arbiter to splitter
  // ------------------------------
  logic      w_mid_req_valid;
  fab_req_t  w_mid_req;
  logic      w_mid_req_ready;
  logic      w_mid_resp_valid;
  fab_resp_t w_mid_resp;
  logic      w_mid_resp_ready;

  // targets
  logic      w_ram_req_valid;
  fab_req_t  w_ram_req;
  logic      w_ram_req_ready;
  logic      w_ram_resp_valid;
  fab_resp_t w_ram_resp;
  logic      w_ram_resp_ready;

  logic      w_serial_req_valid;
  fab_req_t  w_serial_req;
  logic      w_serial_req_ready;
  logic      w_serial_resp_valid;
  fab_resp_t w_serial_resp;
  logic      w_serial_resp_ready;

  scariv_l2c_arbiter u_arbiter (
    .i_clk             (i_clk),
    .i_scariv_reset_n  (i_scariv_reset_n),
    .i_ldr_req_valid   (i_ldr_req_valid),
    .i_ldr_req         (i_ldr_req),
    .o_ldr_req_ready   (o_ldr_req_ready),
    .o_ldr_resp_valid  (o_ldr_resp_valid),
    .o_ldr_resp        (o_ldr_resp),
    .i_ldr_resp_ready  (i_ldr_resp_ready),
    .i_core_req_valid  (i_core_req_valid),
    .i_core_req        (i_core_req),
    .o_core_req_ready  (o_core_req_ready),
    .o_core_resp_valid (o_core_resp_valid),
    .o_core_resp       (o_core_resp),
    .i_core_resp_ready (i_core_resp_ready),
    .o_fab_req_valid   (w_mid_req_valid),
    .o_fab_req         (w_mid_req),
    .i_fab_req_ready   (w_mid_req_ready),
    .i_fab_resp_valid  (w_mid_resp_valid),
    .i_fab_resp        (w_mid_resp),
    .o_fab_resp_ready  (w_mid_resp_ready)
  );

  scariv_l2c_splitter u_splitter (
    .i_clk               (i_clk),
    .i_scariv_reset_n    (i_scariv_reset_n),
    .i_req_valid         (w_mid_req_valid),
    .i_req               (w_mid_req),
    .o_req_ready         (w_mid_req_ready),
    .o_resp_valid        (w_mid_resp_valid),
    .o_resp              (w_mid_resp),
    .i_resp_ready        (w_mid_resp_ready),
    .o_ram_req_valid     (w_ram_req_valid),
    .o_ram_req           (w_ram_req),
    .i_ram_req_ready     (w_ram_req_ready),
    .i_ram_resp_valid    (w_ram_resp_valid),
    .i_ram_resp          (w_ram_resp),
    .o_ram_resp_ready    (w_ram_resp_ready),
    .o_serial_req_valid  (w_serial_req_valid),
    .o_serial_req        (w_serial_req),
    .i_serial_req_ready  (w_serial_req_ready),
    .i_serial_resp_valid (w_serial_resp_valid),
    .i_serial_resp       (w_serial_resp),
    .o_serial_resp_ready (w_serial_resp_ready),
    .o_decode_err        (o_decode_err)
  );

  scariv_l2c_ram u_ram (
    .i_clk            (i_clk),
    .i_scariv_reset_n (i_scariv_reset_n),
    .i_req_valid      (w_ram_req_valid),
    .i_req            (w_ram_req),
    .o_req_ready      (w_ram_req_ready),
    .o_resp_valid     (w_ram_resp_valid),
    .o_resp           (w_ram_resp),
    .i_resp_ready     (w_ram_resp_ready)
  );

  scariv_l2c_serial u_serial (
    .i_clk            (i_clk),
    .i_scariv_reset_n (i_scariv_reset_n),
    .i_req_valid      (w_serial_req_valid),
    .i_req            (w_serial_req),
    .o_req_ready      (w_serial_req_ready),
    .o_resp_valid     (w_serial_resp_valid),
    .o_resp           (w_serial_resp),
    .i_resp_ready     (w_serial_resp_ready),
    .o_serial_valid   (o_serial_valid),
    .o_serial_char    (o_serial_char)
  );

endmodule

`default_nettype wire

// File: scariv_l2c_pkg.sv
`default_nettype none

package scariv_l2c_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int PADDR_W      = 40;
  localparam int L2_DATA_W    = 128;
  localparam int L2_DATA_B_W  = L2_DATA_W / 8;  // 16 bytes per word
  localparam int L2_CMD_TAG_W = 4;

  typedef logic [PADDR_W-1:0]      paddr_t;
  typedef logic [L2_DATA_W-1:0]    l2_data_t;
  typedef logic [L2_DATA_B_W-1:0]  l2_strb_t;
  typedef logic [L2_CMD_TAG_W-1:0] req_tag_t;

  typedef enum logic {
    M_XRD,
    M_XWR
  } mem_cmd_t;

  // source bit stamped by the arbiter
  localparam logic SRC_LDR  = 1'b0;
  localparam logic SRC_CORE = 1'b1;

  typedef struct packed {
    logic     src;
    req_tag_t tag;
  } fab_tag_t;

  typedef struct packed {
    mem_cmd_t cmd;
    paddr_t   addr;
    req_tag_t tag;
    l2_data_t data;
    l2_strb_t byte_en;
  } l2_req_t;

  typedef struct packed {
    mem_cmd_t cmd;
    paddr_t   addr;
    fab_tag_t tag;
    l2_data_t data;
    l2_strb_t byte_en;
  } fab_req_t;

  typedef struct packed {
    req_tag_t tag;
    l2_data_t data;
  } l2_resp_t;

  typedef struct packed {
    fab_tag_t tag;
    l2_data_t data;
  } fab_resp_t;

  // ------------------------------
  // address map and latencies
  // ------------------------------
  localparam paddr_t RAM_BASE_ADDR    = 40'h00_8000_0000;
  localparam paddr_t RAM_SIZE         = 40'h00_0000_4000;
  localparam int     RAM_RD_LAT       = 10;
  localparam int     RAM_WORDS        = int'(RAM_SIZE) / L2_DATA_B_W;
  localparam int     RAM_IDX_W        = $clog2(RAM_WORDS);
  localparam int     RAM_OFS_W        = $clog2(L2_DATA_B_W);

  localparam paddr_t SERIAL_BASE_ADDR = 40'h00_5400_0000;
  localparam paddr_t SERIAL_SIZE      = 40'h00_0000_1000;
  localparam int     SERIAL_RD_LAT    = 2;
  localparam int     SERIAL_LAT_W     = $clog2(SERIAL_RD_LAT + 1);
  localparam int     SERIAL_CNT_W     = 32;

endpackage

`default_nettype wire

// File: scariv_l2c_ram.sv
`default_nettype none

module scariv_l2c_ram
  import scariv_l2c_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_scariv_reset_n,

  input  logic      i_req_valid,
  input  fab_req_t  i_req,
  output logic      o_req_ready,

  output logic      o_resp_valid,
  output fab_resp_t o_resp,
  input  logic      i_resp_ready
);

  l2_data_t              r_ram [RAM_WORDS];
  logic [RAM_WORDS-1:0]  r_written;     // untouched words read as zero
  logic [RAM_RD_LAT-1:0] r_pipe_valid;
  fab_resp_t             r_pipe_resp [RAM_RD_LAT];

  logic                  w_stall;
  logic                  w_req_fire;
  logic                  w_wr_fire;
  logic                  w_rd_fire;
  logic [RAM_IDX_W-1:0]  w_idx;
  l2_data_t              w_rd_data;

  // head not taken, whole pipe freezes
  assign w_stall     = r_pipe_valid[RAM_RD_LAT-1] & ~i_resp_ready;
  assign o_req_ready = ~w_stall;

  assign w_req_fire = i_req_valid & o_req_ready;
  assign w_wr_fire  = w_req_fire & (i_req.cmd == M_XWR);
  assign w_rd_fire  = w_req_fire & (i_req.cmd == M_XRD);
  assign w_idx      = i_req.addr[RAM_OFS_W +: RAM_IDX_W];
  assign w_rd_data  = r_written[w_idx] ? r_ram[w_idx] : '0;

  // ------------------------------
  // storage
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (w_wr_fire) begin
      for (int b = 0; b < L2_DATA_B_W; b++) begin
        if (i_req.byte_en[b]) begin
          r_ram[w_idx][b*8 +: 8] <= i_req.data[b*8 +: 8];
        end else if (!r_written[w_idx]) begin
          r_ram[w_idx][b*8 +: 8] <= 8'h00;  // first write clears the other bytes
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_scariv_reset_n) begin
      r_written <= '0;
    end else if (w_wr_fire) begin
      r_written[w_idx] <= 1'b1;
    end
  end

  // ------------------------------
  // read pipeline
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (i_scariv_reset_n) begin
      r_pipe_valid <= '0;
    end else if (~w_stall) begin
      r_pipe_valid <= {r_pipe_valid[RAM_RD_LAT-2:0], w_rd_fire};
    end
  end

  always_ff @(posedge i_clk) begin
    if (~w_stall) begin
      r_pipe_resp[0] <= '{tag: i_req.tag, data: w_rd_data};  // data sampled at accept
      for (int s = 1; s < RAM_RD_LAT; s++) begin
        r_pipe_resp[s] <= r_pipe_resp[s-1];
      end
    end
  end

  assign o_resp_valid = r_pipe_valid[RAM_RD_LAT-1];
  assign o_resp       = r_pipe_resp[RAM_RD_LAT-1];

  a_resp_stable: assert property (@(posedge i_clk) disable iff (i_scariv_reset_n)
    o_resp_valid & ~i_resp_ready |=> o_resp_valid && $stable(o_resp));

endmodule

`default_nettype wire

// File: scariv_l2c_serial.sv
`default_nettype none

module scariv_l2c_serial
  import scariv_l2c_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_scariv_reset_n,

  input  logic       i_req_valid,
  input  fab_req_t   i_req,
  output logic       o_req_ready,

  output logic       o_resp_valid,
  output fab_resp_t  o_resp,
  input  logic       i_resp_ready,

  output logic       o_serial_valid,
  output logic [7:0] o_serial_char
);

  logic                    r_rd_pend;
  logic [SERIAL_LAT_W-1:0] r_wait;
  fab_tag_t                r_tag;
  logic [SERIAL_CNT_W-1:0] r_char_cnt;
  logic                    r_serial_valid;
  logic [7:0]              r_serial_char;
  logic [7:0]              w_char;
  logic                    w_req_fire;

  assign o_req_ready  = ~r_rd_pend;  // blocked while a read is open
  assign w_req_fire   = i_req_valid & o_req_ready;
  assign o_resp_valid = r_rd_pend & (r_wait == '0);
  assign o_resp       = '{tag: r_tag, data: l2_data_t'(r_char_cnt)};

  // lowest enabled byte
  always_comb begin
    w_char = '0;
    for (int b = L2_DATA_B_W - 1; b >= 0; b--) begin
      if (i_req.byte_en[b]) begin
        w_char = i_req.data[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_scariv_reset_n) begin
      r_rd_pend      <= 1'b0;
      r_wait         <= '0;
      r_char_cnt     <= '0;
      r_serial_valid <= 1'b0;
    end else begin
      r_serial_valid <= w_req_fire & (i_req.cmd == M_XWR);
      if (w_req_fire && (i_req.cmd == M_XWR)) begin
        r_char_cnt <= r_char_cnt + 1'b1;
      end
      if (w_req_fire && (i_req.cmd == M_XRD)) begin
        r_rd_pend <= 1'b1;
        r_wait    <= SERIAL_LAT_W'(SERIAL_RD_LAT - 1);
      end else if (o_resp_valid && i_resp_ready) begin
        r_rd_pend <= 1'b0;
      end else if (r_wait != '0) begin
        r_wait <= r_wait - 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_req_fire) begin
      r_tag <= i_req.tag;
    end
    if (w_req_fire && (i_req.cmd == M_XWR)) begin
      r_serial_char <= w_char;
    end
  end

  assign o_serial_valid = r_serial_valid;
  assign o_serial_char  = r_serial_char;

endmodule

`default_nettype wire

// File: scariv_l2c_splitter.sv
`default_nettype none

module scariv_l2c_splitter
  import scariv_l2c_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_scariv_reset_n,

  // from arbiter
  input  logic      i_req_valid,
  input  fab_req_t  i_req,
  output logic      o_req_ready,
  output logic      o_resp_valid,
  output fab_resp_t o_resp,
  input  logic      i_resp_ready,

  // RAM target
  output logic      o_ram_req_valid,
  output fab_req_t  o_ram_req,
  input  logic      i_ram_req_ready,
  input  logic      i_ram_resp_valid,
  input  fab_resp_t i_ram_resp,
  output logic      o_ram_resp_ready,

  // serial target
  output logic      o_serial_req_valid,
  output fab_req_t  o_serial_req,
  input  logic      i_serial_req_ready,
  input  logic      i_serial_resp_valid,
  input  fab_resp_t i_serial_resp,
  output logic      o_serial_resp_ready,

  output logic      o_decode_err
);

  logic w_ram_hit;
  logic w_serial_hit;
  logic w_miss;

  // ------------------------------
  // address decode
  // ------------------------------
  assign w_ram_hit    = (i_req.addr >= RAM_BASE_ADDR) &&
                        (i_req.addr <  RAM_BASE_ADDR + RAM_SIZE);
  assign w_serial_hit = (i_req.addr >= SERIAL_BASE_ADDR) &&
                        (i_req.addr <  SERIAL_BASE_ADDR + SERIAL_SIZE);
  assign w_miss       = ~w_ram_hit & ~w_serial_hit;

  assign o_ram_req_valid    = i_req_valid & w_ram_hit;
  assign o_ram_req          = i_req;
  assign o_serial_req_valid = i_req_valid & w_serial_hit;
  assign o_serial_req       = i_req;

  always_comb begin
    if (w_ram_hit) begin
      o_req_ready = i_ram_req_ready;
    end else if (w_serial_hit) begin
      o_req_ready = i_serial_req_ready;
    end else begin
      o_req_ready = 1'b1;  // unmapped, swallowed
    end
  end

  assign o_decode_err = i_req_valid & w_miss;

  // ------------------------------
  // response merge, RAM first
  // ------------------------------
  assign o_resp_valid        = i_ram_resp_valid | i_serial_resp_valid;
  assign o_resp              = i_ram_resp_valid ? i_ram_resp : i_serial_resp;
  assign o_ram_resp_ready    = i_resp_ready;
  assign o_serial_resp_ready = i_resp_ready & ~i_ram_resp_valid;

  a_one_target: assert property (@(posedge i_clk) disable iff (i_scariv_reset_n)
    $onehot0({o_ram_req_valid, o_serial_req_valid, o_decode_err}));

  // a serial response losing to the RAM is still there next cycle
  a_serial_wait: assert property (@(posedge i_clk) disable iff (i_scariv_reset_n)
    i_serial_resp_valid & ~o_serial_resp_ready |=>
      i_serial_resp_valid && $stable(i_serial_resp));

endmodule

`default_nettype wire

// File: tb_scariv_l2c.sv
`default_nettype none

module tb_scariv_l2c
  import scariv_l2c_pkg::*;
();

  localparam int N_TAGS      = 1 << L2_CMD_TAG_W;
  localparam int N_T1        = 200;
  localparam int N_T2        = 200;
  localparam int N_T3        = 400;
  localparam int N_TXN       = N_T1 + N_T2 + 2 * N_T3;
  localparam int WDOG_CYCLES = N_TXN * RAM_RD_LAT * 20;

  logic       i_clk;
  logic       i_scariv_reset_n;
  logic       ldr_req_valid;
  l2_req_t    ldr_req;
  logic       ldr_resp_ready;
  logic       core_req_valid;
  l2_req_t    core_req;
  logic       core_resp_ready;
  logic       o_ldr_req_ready;
  logic       o_ldr_resp_valid;
  l2_resp_t   o_ldr_resp;
  logic       o_core_req_ready;
  logic       o_core_resp_valid;
  l2_resp_t   o_core_resp;
  logic       o_serial_valid;
  logic [7:0] o_serial_char;
  logic       o_decode_err;

  // ------------------------------
  // reference model state
  // ------------------------------
  logic        pend_vld [2];
  l2_req_t     pend_req [2];
  int          left_cnt [2];
  logic        rd_out [2][N_TAGS];   // read outstanding per source and tag
  l2_data_t    rd_exp [2][N_TAGS];
  l2_data_t    mem_model [int];      // word index -> data
  logic [7:0]  char_q [$];
  logic [31:0] ser_cnt;
  logic        exp_err;
  int          n_checks;
  int          n_errors;
  int          n_dec_err;
  int          n_chars;

  scariv_l2c_fabric i_dut (
    .i_clk             (i_clk),
    .i_scariv_reset_n  (i_scariv_reset_n),
    .i_ldr_req_valid   (ldr_req_valid),
    .i_ldr_req         (ldr_req),
    .o_ldr_req_ready   (o_ldr_req_ready),
    .o_ldr_resp_valid  (o_ldr_resp_valid),
    .o_ldr_resp        (o_ldr_resp),
    .i_ldr_resp_ready  (ldr_resp_ready),
    .i_core_req_valid  (core_req_valid),
    .i_core_req        (core_req),
    .o_core_req_ready  (o_core_req_ready),
    .o_core_resp_valid (o_core_resp_valid),
    .o_core_resp       (o_core_resp),
    .i_core_resp_ready (core_resp_ready),
    .o_serial_valid    (o_serial_valid),
    .o_serial_char     (o_serial_char),
    .o_decode_err      (o_decode_err)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_resp(input string name, input l2_resp_t got, input l2_resp_t exp);
    n_checks++;
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h exp %h", $time, name, got, exp);
      n_errors++;
    end
  endtask

  task automatic check_char(input logic [7:0] got, input logic [7:0] exp);
    n_checks++;
    n_chars++;
    if (got !== exp) begin
      $display("[FAIL] %0t o_serial_char got %h exp %h", $time, got, exp);
      n_errors++;
    end
  endtask

  task automatic check_err(input logic got, input logic exp);
    if (got === 1'b1) n_dec_err++;
    if (exp) n_checks++;
    if (got !== exp) begin
      $display("[FAIL] %0t o_decode_err got %b exp %b", $time, got, exp);
      n_errors++;
    end
  endtask

  // pick a free tag and a random target, nothing issued if all tags busy
  task automatic new_req(input int s);
    int      t0;
    int      t;
    int      kind;
    int      free_tag;
    l2_req_t r;
    free_tag = -1;
    t0 = int'($urandom % N_TAGS);
    for (int k = 0; k < N_TAGS; k++) begin
      t = (t0 + k) % N_TAGS;
      if (free_tag < 0 && !rd_out[s][t]) free_tag = t;
    end
    if (free_tag < 0) return;
    kind      = int'($urandom % 16);
    r.cmd     = ($urandom % 2 == 0) ? M_XWR : M_XRD;
    r.tag     = req_tag_t'(free_tag);
    r.data    = {$urandom, $urandom, $urandom, $urandom};
    r.byte_en = ($urandom % 4 == 0) ? '1 : l2_strb_t'($urandom);
    if (kind < 11) begin
      r.addr = RAM_BASE_ADDR + paddr_t'(($urandom % 128) * 16 + ($urandom % 16));
    end else if (kind < 15) begin
      r.addr = SERIAL_BASE_ADDR + paddr_t'($urandom % 32'h1000);
    end else begin
      r.addr = 40'h00_6000_0000 + paddr_t'($urandom % 32'h10000);  // unmapped hole
    end
    pend_req[s] = r;
    pend_vld[s] = 1'b1;
  endtask

  // model update at acceptance
  task automatic accept(input int s, input l2_req_t r);
    int         idx;
    l2_data_t   w;
    logic [7:0] ch;
    logic       found;
    if (r.addr >= RAM_BASE_ADDR && r.addr < RAM_BASE_ADDR + RAM_SIZE) begin
      idx = int'((r.addr - RAM_BASE_ADDR) >> RAM_OFS_W);
      w = mem_model.exists(idx) ? mem_model[idx] : '0;
      if (r.cmd == M_XWR) begin
        for (int b = 0; b < L2_DATA_B_W; b++) begin
          if (r.byte_en[b]) w[b*8 +: 8] = r.data[b*8 +: 8];
        end
        mem_model[idx] = w;
      end else begin
        rd_out[s][r.tag] = 1'b1;
        rd_exp[s][r.tag] = w;
      end
    end else if (r.addr >= SERIAL_BASE_ADDR && r.addr < SERIAL_BASE_ADDR + SERIAL_SIZE) begin
      if (r.cmd == M_XWR) begin
        ch    = 8'h00;
        found = 1'b0;
        for (int b = 0; b < L2_DATA_B_W; b++) begin
          if (!found && r.byte_en[b]) begin
            ch    = r.data[b*8 +: 8];
            found = 1'b1;
          end
        end
        char_q.push_back(ch);
        ser_cnt = ser_cnt + 32'd1;
      end else begin
        rd_out[s][r.tag] = 1'b1;
        rd_exp[s][r.tag] = l2_data_t'(ser_cnt);
      end
    end else begin
      exp_err = 1'b1;
    end
    pend_vld[s] = 1'b0;
    left_cnt[s] = left_cnt[s] - 1;
  endtask

  task automatic take_resp(input int s, input l2_resp_t got, input string name);
    l2_resp_t exp;
    if (!rd_out[s][got.tag]) begin
      $display("%0t %s returned tag %0d but no read with that tag is outstanding",
               $time, name, got.tag);
      n_errors++;
    end else begin
      exp.tag  = got.tag;
      exp.data = rd_exp[s][got.tag];
      check_resp(name, got, exp);
      rd_out[s][got.tag] = 1'b0;
    end
  endtask

  function automatic logic busy();
    logic b;
    b = (left_cnt[0] > 0) || (left_cnt[1] > 0) || pend_vld[0] || pend_vld[1];
    for (int t = 0; t < N_TAGS; t++) begin
      if (rd_out[0][t] || rd_out[1][t]) b = 1'b1;
    end
    return b || (char_q.size() != 0);
  endfunction

  // ------------------------------
  // one test: issue, then drain
  // ------------------------------
  task automatic run_test(input string name, input int n_ldr, input int n_core, input int bp);
    int errs_before;
    errs_before = n_errors;
    left_cnt[0] = n_ldr;
    left_cnt[1] = n_core;
    while (busy()) begin
      @(posedge i_clk);
      #1;
      for (int s = 0; s < 2; s++) begin
        if (!pend_vld[s] && left_cnt[s] > 0 && $urandom % 4 != 0) new_req(s);
      end
      ldr_req_valid   = pend_vld[0];
      ldr_req         = pend_req[0];
      core_req_valid  = pend_vld[1];
      core_req        = pend_req[1];
      ldr_resp_ready  = int'($urandom % 100) >= bp;
      core_resp_ready = int'($urandom % 100) >= bp;
      @(negedge i_clk);  // everything settled until the next edge
      exp_err = 1'b0;
      if (o_ldr_resp_valid && ldr_resp_ready) take_resp(0, o_ldr_resp, "o_ldr_resp");
      if (o_core_resp_valid && core_resp_ready) take_resp(1, o_core_resp, "o_core_resp");
      if (o_serial_valid) begin
        if (char_q.size() == 0) begin
          $display("%0t serial device emitted a character that no write produced", $time);
          n_errors++;
        end else begin
          check_char(o_serial_char, char_q.pop_front());
        end
      end
      if (ldr_req_valid && o_ldr_req_ready) accept(0, ldr_req);
      if (core_req_valid && o_core_req_ready) accept(1, core_req);
      check_err(o_decode_err, exp_err);
    end
    $display("test %s done, %0d errors", name, n_errors - errs_before);
  endtask

  initial begin
    void'($urandom(32'h68e0));
    i_scariv_reset_n = 1'b1;
    ldr_req_valid    = 1'b0;
    ldr_req          = '0;
    ldr_resp_ready   = 1'b1;
    core_req_valid   = 1'b0;
    core_req         = '0;
    core_resp_ready  = 1'b1;
    ser_cnt          = '0;
    n_checks         = 0;
    n_errors         = 0;
    n_dec_err        = 0;
    n_chars          = 0;
    for (int s = 0; s < 2; s++) begin
      pend_vld[s] = 1'b0;
      pend_req[s] = '0;
      left_cnt[s] = 0;
      for (int t = 0; t < N_TAGS; t++) rd_out[s][t] = 1'b0;
    end
    repeat (8) @(posedge i_clk);
    #1 i_scariv_reset_n = 1'b0;
    run_test("loader_only", N_T1, 0, 0);
    run_test("core_only", 0, N_T2, 25);
    run_test("both_backpressure", N_T3, N_T3, 40);
    $display("checks %0d errors %0d decode_err %0d chars %0d",
             n_checks, n_errors, n_dec_err, n_chars);
    if (n_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WDOG_CYCLES) @(posedge i_clk);
    $display("watchdog expired after %0d cycles with work still outstanding", WDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire
